// ==== common/fabricIf.sv ====
// ==============================
// Fabric transaction bundle
// One transaction plus its valid
// ==============================

`timescale 1ns/1ps

interface fabricIf;

    logic                valid;
    tilePkg::address     addr;
    tilePkg::word        data;
    tilePkg::opcode      op;
    tilePkg::tileId      requestorId;  // Tile that issued it

    // Producer side
    modport src (output valid, addr, data, op, requestorId);

    // Consumer side
    modport dst (input valid, addr, data, op, requestorId);

endinterface

// ==== common/tilePkg.sv ====
// ==============================
// Tile memory wrapper package
// Transaction field types, region map,
// memory and FIFO sizes
// ==============================

package tilePkg;

    // ==============================
    // Field types
    // ==============================
    typedef logic [7:0]  tileId;   // Tile number
    typedef logic [31:0] word;     // Data word
    typedef logic [31:0] address;  // Tile id, region, word index
    typedef logic [1:0]  opcode;   // Transaction kind
    typedef logic [3:0]  region;   // Region field of an address

    // Transaction kinds
    localparam opcode opRd    = 2'd0;
    localparam opcode opWr    = 2'd1;
    localparam opcode opRdRsp = 2'd2;

    // ==============================
    // Address map
    // ==============================
    localparam int tileIdLsb = 24;   // Tile id in bits 31..24
    localparam int regionLsb = 20;   // Region in bits 23..20

    localparam region imemRegion = 4'd0;  // Instruction memory
    localparam region dmemRegion = 4'd1;  // Data memory

    // 1024 words per memory, word index in bits 11..2
    localparam int memAddrWidth = 10;

    // Core read of this address answers with the local tile id
    localparam address whoAmIAddress = 32'h00FF_FFFF;

    // Outgoing queues
    localparam int fifoDepth = 2;

endpackage

// ==== hdl/coreDataAlign.sv ====
// ==============================
// Core data-side aligner
// Shifts stores into byte lanes, right-aligns
// loads, answers the WhoAmI read
// ==============================

`timescale 1ns/1ps

module coreDataAlign (
    input  logic            Clock,
    input  tilePkg::tileId  localTileId,
    // Core access, cycle n
    input  tilePkg::address dmemAddress,
    input  tilePkg::word    dmemWrData,
    input  logic [3:0]      dmemByteEn,
    input  logic            dmemRdEn,
    // Towards the data memory
    output tilePkg::word    alignWrData,
    output logic [3:0]      alignByteEn,
    // Memory word and load result, cycle n+1
    input  tilePkg::word    ramRdData,
    output tilePkg::word    dmemRdRsp
);

    logic [1:0] offset;
    logic [1:0] offsetQ;    // Offset of the load in flight
    logic       whoAmI;
    logic       whoAmIQ;

    assign offset = dmemAddress[1:0];

    // ==============================
    // Store side
    // ==============================
    always_comb begin
        alignWrData = dmemWrData << {offset, 3'b000};  // Byte offset to bit shift
        alignByteEn = dmemByteEn << offset;            // Lanes past bit 3 drop off
    end

    assign whoAmI = dmemRdEn && (dmemAddress == tilePkg::whoAmIAddress);

    always_ff @(posedge Clock) begin
        offsetQ <= offset;
        whoAmIQ <= whoAmI;
    end

    // ==============================
    // Load side
    // ==============================
    // Zero-filled from the top
    assign dmemRdRsp = whoAmIQ ? {24'b0, localTileId}
                               : ramRdData >> {offsetQ, 3'b000};

endmodule

// ==== hdl/dualPortRam.sv ====
// ==============================
// Dual-port word memory
// Port A with byte enables, port B full-word
// Registered reads on both ports
// ==============================

`timescale 1ns/1ps

module dualPortRam #(
    parameter int addrWidth = 10
) (
    input  logic                 Clock,
    // Port A, byte writes
    input  logic [addrWidth-1:0] addressA,
    input  tilePkg::word         dataA,
    input  logic [3:0]           byteEnA,
    input  logic                 wrEnA,
    output tilePkg::word         qA,
    // Port B, word writes
    input  logic [addrWidth-1:0] addressB,
    input  tilePkg::word         dataB,
    input  logic                 wrEnB,
    output tilePkg::word         qB
);

    tilePkg::word mem [2**addrWidth];

    always_ff @(posedge Clock) begin
        for (int i = 0; i < 4; i++) begin
            if (wrEnA && byteEnA[i]) begin
                mem[addressA][8*i +: 8] <= dataA[8*i +: 8];  // Enabled lanes only
            end
        end
        if (wrEnB) begin
            mem[addressB] <= dataB;
        end
        // Old data on read-during-write
        qA <= mem[addressA];
        qB <= mem[addressB];
    end

endmodule

// ==== hdl/memWrapCtrl.sv ====
// ==============================
// Memory wrapper control
// Address decode, response and request building,
// round-robin output arbitration, ready
// ==============================

`timescale 1ns/1ps

module memWrapCtrl (
    input  logic            Clock,
    input  logic            reset,
    input  tilePkg::tileId  localTileId,
    // Incoming fabric transaction
    input  logic            inFabricValid,
    input  tilePkg::address inFabricAddr,
    input  tilePkg::word    inFabricData,
    input  tilePkg::opcode  inFabricOp,
    input  tilePkg::tileId  inFabricRequestorId,
    // Core data access
    input  tilePkg::address dmemAddress,
    input  tilePkg::word    dmemWrData,
    input  logic            dmemWrEn,
    input  logic            dmemRdEn,
    // Memory side
    input  tilePkg::word    imemFabRdData,
    input  tilePkg::word    dmemFabRdData,
    output logic            imemFabWrEn,
    output logic            dmemFabWrEn,
    output logic            dmemLocalWrEn,
    // FIFO side
    fabricIf.src            rspIn,
    fabricIf.src            reqIn,
    fabricIf.dst            rspHead,
    fabricIf.dst            reqHead,
    output logic            rspPop,
    output logic            reqPop,
    input  logic            rspAlmostFull,
    input  logic            reqFull,
    // Outgoing fabric transaction
    input  logic            fabReady,
    output logic            outFabricValid,
    output tilePkg::address outFabricAddr,
    output tilePkg::word    outFabricData,
    output tilePkg::opcode  outFabricOp,
    output tilePkg::tileId  outFabricRequestorId,
    output logic            ready
);

    tilePkg::region  inRegion;
    tilePkg::region  rdRegionQ;    // Region of the read in flight
    tilePkg::address rdRspAddrQ;
    tilePkg::tileId  coreTile;
    logic            coreLocal;
    logic            fabRead;
    logic            rdPendingQ;
    logic            rspGrant;
    logic            reqGrant;
    logic            rspPriorityQ; // Response head wins a tie

    // ==============================
    // Fabric writes
    // ==============================
    assign inRegion = inFabricAddr[tilePkg::regionLsb +: 4];
    assign fabRead  = inFabricValid && (inFabricOp == tilePkg::opRd);

    assign imemFabWrEn = inFabricValid && (inFabricOp == tilePkg::opWr)
                      && (inRegion == tilePkg::imemRegion);
    assign dmemFabWrEn = inFabricValid && (inFabricOp == tilePkg::opWr)
                      && (inRegion == tilePkg::dmemRegion);

    // ==============================
    // Core accesses
    // ==============================
    // Tile id zero also means this tile
    assign coreTile  = dmemAddress[tilePkg::tileIdLsb +: 8];
    assign coreLocal = (coreTile == localTileId) || (coreTile == '0);

    assign dmemLocalWrEn = dmemWrEn && coreLocal;

    // Non-local access leaves as a request
    assign reqIn.valid       = (dmemWrEn || dmemRdEn) && !coreLocal;
    assign reqIn.addr        = dmemAddress;
    assign reqIn.data        = dmemWrData;
    assign reqIn.op          = dmemWrEn ? tilePkg::opWr : tilePkg::opRd;
    assign reqIn.requestorId = localTileId;

    // ==============================
    // Read responses
    // ==============================
    always_ff @(posedge Clock) begin
        if (reset) begin
            rdPendingQ <= 1'b0;
        end else begin
            rdPendingQ <= fabRead;
        end
    end

    always_ff @(posedge Clock) begin
        rdRegionQ  <= inRegion;
        rdRspAddrQ <= {inFabricRequestorId, inFabricAddr[tilePkg::tileIdLsb-1:0]};  // Back to sender
    end

    // Memory word lands one cycle after the request
    assign rspIn.valid       = rdPendingQ;
    assign rspIn.addr        = rdRspAddrQ;
    assign rspIn.op          = tilePkg::opRdRsp;
    assign rspIn.requestorId = localTileId;
    assign rspIn.data        = (rdRegionQ == tilePkg::imemRegion) ? imemFabRdData :
                               (rdRegionQ == tilePkg::dmemRegion) ? dmemFabRdData :
                                                                    '0;  // Unmapped region

    // ==============================
    // Output arbitration
    // ==============================
    assign rspGrant = fabReady && rspHead.valid && (rspPriorityQ || !reqHead.valid);
    assign reqGrant = fabReady && reqHead.valid && !rspGrant;

    always_ff @(posedge Clock) begin
        if (reset) begin
            rspPriorityQ <= 1'b1;
        end else if (rspGrant) begin
            rspPriorityQ <= 1'b0;  // Other side next
        end else if (reqGrant) begin
            rspPriorityQ <= 1'b1;
        end
    end

    assign rspPop = rspGrant;
    assign reqPop = reqGrant;

    assign outFabricValid       = rspGrant || reqGrant;
    assign outFabricAddr        = rspGrant ? rspHead.addr        : reqHead.addr;
    assign outFabricData        = rspGrant ? rspHead.data        : reqHead.data;
    assign outFabricOp          = rspGrant ? rspHead.op          : reqHead.op;
    assign outFabricRequestorId = rspGrant ? rspHead.requestorId : reqHead.requestorId;

    // One spare response entry covers the read already in flight
    assign ready = !rspAlmostFull && !reqFull;

    noTrafficWhenBusy: assert property (@(posedge Clock) disable iff (reset)
        !ready |-> !inFabricValid);

endmodule

// ==== hdl/tileMemWrap.sv ====
// ==============================
// Tile memory wrapper top
// Instruction and data memories, fabric
// response and request queues
// ==============================

`timescale 1ns/1ps

module tileMemWrap (
    input  logic            Clock,
    input  logic            reset,
    input  tilePkg::tileId  localTileId,
    // Instruction fetch
    input  tilePkg::address pc,
    output tilePkg::word    instruction,
    // Core data access
    input  tilePkg::address dmemAddress,
    input  tilePkg::word    dmemWrData,
    input  logic [3:0]      dmemByteEn,
    input  logic            dmemWrEn,
    input  logic            dmemRdEn,
    output tilePkg::word    dmemRdRsp,
    // Incoming fabric transaction
    input  logic            inFabricValid,
    input  tilePkg::address inFabricAddr,
    input  tilePkg::word    inFabricData,
    input  tilePkg::opcode  inFabricOp,
    input  tilePkg::tileId  inFabricRequestorId,
    // Outgoing fabric transaction
    output logic            outFabricValid,
    output tilePkg::address outFabricAddr,
    output tilePkg::word    outFabricData,
    output tilePkg::opcode  outFabricOp,
    output tilePkg::tileId  outFabricRequestorId,
    input  logic            fabReady,
    output logic            ready
);

    tilePkg::word imemFabRdData;
    tilePkg::word dmemFabRdData;
    tilePkg::word alignWrData;
    tilePkg::word ramRdData;     // Unaligned core load word
    logic [3:0]   alignByteEn;
    logic         imemFabWrEn;
    logic         dmemFabWrEn;
    logic         dmemLocalWrEn;
    logic         rspPop;
    logic         reqPop;
    logic         rspAlmostFull;
    logic         reqFull;

    fabricIf rspIn ();    // Response into its FIFO
    fabricIf reqIn ();    // Request into its FIFO
    fabricIf rspHead ();
    fabricIf reqHead ();

    // ==============================
    // Control
    // ==============================
    memWrapCtrl u_ctrl (
        .Clock                (Clock),
        .reset                (reset),
        .localTileId          (localTileId),
        .inFabricValid        (inFabricValid),
        .inFabricAddr         (inFabricAddr),
        .inFabricData         (inFabricData),
        .inFabricOp           (inFabricOp),
        .inFabricRequestorId  (inFabricRequestorId),
        .dmemAddress          (dmemAddress),
        .dmemWrData           (dmemWrData),
        .dmemWrEn             (dmemWrEn),
        .dmemRdEn             (dmemRdEn),
        .imemFabRdData        (imemFabRdData),
        .dmemFabRdData        (dmemFabRdData),
        .imemFabWrEn          (imemFabWrEn),
        .dmemFabWrEn          (dmemFabWrEn),
        .dmemLocalWrEn        (dmemLocalWrEn),
        .rspIn                (rspIn),
        .reqIn                (reqIn),
        .rspHead              (rspHead),
        .reqHead              (reqHead),
        .rspPop               (rspPop),
        .reqPop               (reqPop),
        .rspAlmostFull        (rspAlmostFull),
        .reqFull              (reqFull),
        .fabReady             (fabReady),
        .outFabricValid       (outFabricValid),
        .outFabricAddr        (outFabricAddr),
        .outFabricData        (outFabricData),
        .outFabricOp          (outFabricOp),
        .outFabricRequestorId (outFabricRequestorId),
        .ready                (ready)
    );

    // ==============================
    // Memories
    // ==============================
    dualPortRam #(.addrWidth(tilePkg::memAddrWidth)) iMem (
        .Clock    (Clock),
        .addressA (pc[tilePkg::memAddrWidth+1:2]),       // Fetch only
        .dataA    ('0),
        .byteEnA  (4'b0000),
        .wrEnA    (1'b0),
        .qA       (instruction),
        .addressB (inFabricAddr[tilePkg::memAddrWidth+1:2]),
        .dataB    (inFabricData),
        .wrEnB    (imemFabWrEn),
        .qB       (imemFabRdData)
    );

    dualPortRam #(.addrWidth(tilePkg::memAddrWidth)) dMem (
        .Clock    (Clock),
        .addressA (dmemAddress[tilePkg::memAddrWidth+1:2]),
        .dataA    (alignWrData),
        .byteEnA  (alignByteEn),
        .wrEnA    (dmemLocalWrEn),
        .qA       (ramRdData),
        .addressB (inFabricAddr[tilePkg::memAddrWidth+1:2]),
        .dataB    (inFabricData),
        .wrEnB    (dmemFabWrEn),
        .qB       (dmemFabRdData)
    );

    coreDataAlign u_align (
        .Clock       (Clock),
        .localTileId (localTileId),
        .dmemAddress (dmemAddress),
        .dmemWrData  (dmemWrData),
        .dmemByteEn  (dmemByteEn),
        .dmemRdEn    (dmemRdEn),
        .alignWrData (alignWrData),
        .alignByteEn (alignByteEn),
        .ramRdData   (ramRdData),
        .dmemRdRsp   (dmemRdRsp)
    );

    // ==============================
    // Outgoing queues
    // ==============================
    transFifo #(.depth(tilePkg::fifoDepth)) rspFifo (
        .Clock      (Clock),
        .reset      (reset),
        .pushSide   (rspIn),
        .popSide    (rspHead),
        .pop        (rspPop),
        .full       (),
        .almostFull (rspAlmostFull)  // Leaves room for the read in flight
    );

    transFifo #(.depth(tilePkg::fifoDepth)) reqFifo (
        .Clock      (Clock),
        .reset      (reset),
        .pushSide   (reqIn),
        .popSide    (reqHead),
        .pop        (reqPop),
        .full       (reqFull),
        .almostFull ()
    );

endmodule

// ==== hdl/transFifo.sv ====
// ==============================
// Transaction FIFO
// First-word-fall-through, full and
// almost-full flags
// ==============================

`timescale 1ns/1ps

module transFifo #(
    parameter int depth = 2
) (
    input  logic  Clock,
    input  logic  reset,
    fabricIf.dst  pushSide,     // Push on valid
    fabricIf.src  popSide,      // Head, valid when not empty
    input  logic  pop,
    output logic  full,
    output logic  almostFull    // One free entry or fewer
);

    localparam int ptrWidth   = (depth > 1) ? $clog2(depth) : 1;
    localparam int countWidth = $clog2(depth + 1);

    // Storage, one array per field
    tilePkg::address addrMem [depth];
    tilePkg::word    dataMem [depth];
    tilePkg::opcode  opMem   [depth];
    tilePkg::tileId  idMem   [depth];

    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [countWidth-1:0] count;

    // ==============================
    // Pointers and count
    // ==============================
    always_ff @(posedge Clock) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushSide.valid) begin
                wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;  // Wrap
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({pushSide.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (pushSide.valid) begin
            addrMem[wrPtr] <= pushSide.addr;
            dataMem[wrPtr] <= pushSide.data;
            opMem[wrPtr]   <= pushSide.op;
            idMem[wrPtr]   <= pushSide.requestorId;
        end
    end

    // Head falls through
    assign popSide.valid       = (count != '0);
    assign popSide.addr        = addrMem[rdPtr];
    assign popSide.data        = dataMem[rdPtr];
    assign popSide.op          = opMem[rdPtr];
    assign popSide.requestorId = idMem[rdPtr];

    assign full       = (count == countWidth'(depth));
    assign almostFull = (count >= countWidth'(depth - 1));

    // Producer must respect the flags it was given
    noPushWhenFull: assert property (@(posedge Clock) disable iff (reset)
        pushSide.valid |-> !full);

    // Consumer only pops a valid head
    noPopWhenEmpty: assert property (@(posedge Clock) disable iff (reset)
        pop |-> (count != '0));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the tile memory wrapper testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tileMemWrapTb \
    -f sources.f -o tileMemWrapSim || exit 1
./obj_dir/tileMemWrapSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// ==== sources.f ====
common/tilePkg.sv
common/fabricIf.sv
hdl/dualPortRam.sv
hdl/coreDataAlign.sv
hdl/transFifo.sv
hdl/memWrapCtrl.sv
hdl/tileMemWrap.sv
test/tileMemWrapTb.sv

// ==== test/tileMemWrapTb.sv ====
// ==============================
// Tile memory wrapper testbench
// LFSR stimulus against shadow memories
// and expected outgoing transaction queues
// ==============================

`timescale 1ns/1ps

module tileMemWrapTb;

    localparam int clkPeriod   = 20;
    localparam int numWords    = 16;   // Words used in each memory
    localparam int numFetch    = 24;
    localparam int numFabReads = 24;
    localparam int numForward  = 16;
    localparam int stallCycles = 16;
    localparam logic [7:0] myTile = 8'h05;

    // Rough cycle budget of all tests, doubled plus margin for the watchdog
    localparam int stimulusCycles = 10 + 2 * numWords + numFetch + 24 + 2 * numFabReads
                                  + numForward + 2 * numWords + stallCycles;
    localparam int watchdogCycles = 2 * stimulusCycles + 200;

    logic        Clock;
    logic        reset;
    logic [7:0]  localTileId;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic [31:0] dmemAddress;
    logic [31:0] dmemWrData;
    logic [3:0]  dmemByteEn;
    logic        dmemWrEn;
    logic        dmemRdEn;
    logic [31:0] dmemRdRsp;
    logic        inFabricValid;
    logic [31:0] inFabricAddr;
    logic [31:0] inFabricData;
    logic [1:0]  inFabricOp;
    logic [7:0]  inFabricRequestorId;
    logic        outFabricValid;
    logic [31:0] outFabricAddr;
    logic [31:0] outFabricData;
    logic [1:0]  outFabricOp;
    logic [7:0]  outFabricRequestorId;
    logic        fabReady;
    logic        ready;

    logic [31:0] lfsr;
    logic [31:0] imemShadow [1024];
    logic [31:0] dmemShadow [1024];
    logic [73:0] rspQ [$];   // {addr, data, op, requestorId}
    logic [73:0] reqQ [$];
    int          errors   = 0;
    int          checks   = 0;
    int          outCount = 0;

    tileMemWrap u_dut (.*);

    initial begin
        Clock = 1'b0;
        forever #(clkPeriod / 2) Clock = ~Clock;
    end

    // ==============================
    // Helpers
    // ==============================
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] result;
        logic        fb;
        result = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr   = {lfsr[30:0], fb};
            result = {result[30:0], fb};
        end
        return result;
    endfunction

    function automatic logic [73:0] packTrans(input logic [31:0] addr, input logic [31:0] data,
                                              input logic [1:0] op, input logic [7:0] id);
        return {addr, data, op, id};
    endfunction

    // Tile id 0 or own id, both local
    function automatic logic [31:0] localAddr(input logic [9:0] idx, input logic [1:0] off);
        logic [7:0] tile;
        tile = takeBits(1) ? myTile : 8'h00;
        return {tile, 4'h1, 8'h00, idx, off};
    endfunction

    // Top bit set, never 0 or own id
    function automatic logic [31:0] foreignAddr();
        return {1'b1, 7'(takeBits(7)), 4'h1, 8'h00, 10'(takeBits(4)), 2'(takeBits(2))};
    endfunction

    // Zero-filled right shift of the word, WhoAmI answers the tile id
    function automatic logic [31:0] loadValue(input logic [31:0] addr);
        if (addr == 32'h00FF_FFFF) begin
            return {24'h0, myTile};
        end
        return dmemShadow[addr[11:2]] >> (8 * addr[1:0]);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic startFabric(input logic [1:0] op, input logic [3:0] region,
                               input logic [9:0] idx, input logic [31:0] data);
        logic [7:0]  reqId;
        logic [31:0] addr;
        logic [31:0] rdData;
        reqId               = 8'(takeBits(8));
        addr                = {myTile, region, 8'h00, idx, 2'b00};
        inFabricValid       = 1'b1;
        inFabricAddr        = addr;
        inFabricData        = data;
        inFabricOp          = op;
        inFabricRequestorId = reqId;
        if (op == tilePkg::opWr) begin
            if (region == 4'd0) begin
                imemShadow[idx] = data;
            end else if (region == 4'd1) begin
                dmemShadow[idx] = data;
            end
        end else begin
            rdData = (region == 4'd0) ? imemShadow[idx] :
                     (region == 4'd1) ? dmemShadow[idx] : 32'h0;   // Unmapped reads zero
            rspQ.push_back(packTrans({reqId, addr[23:0]}, rdData, tilePkg::opRdRsp, myTile));
        end
    endtask

    task automatic startCore(input logic wr, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] be);
        logic [31:0] shifted;
        logic [3:0]  lanes;
        logic [9:0]  idx;
        shifted     = data << (8 * addr[1:0]);
        lanes       = be << addr[1:0];   // Upper lanes drop off
        idx         = addr[11:2];
        dmemAddress = addr;
        dmemWrData  = data;
        dmemByteEn  = be;
        dmemWrEn    = wr;
        dmemRdEn    = !wr;
        if (addr[31:24] != myTile && addr[31:24] != 8'h00) begin
            reqQ.push_back(packTrans(addr, data, wr ? tilePkg::opWr : tilePkg::opRd, myTile));
        end else if (wr) begin
            for (int l = 0; l < 4; l++) begin
                if (lanes[l]) begin
                    dmemShadow[idx][8*l +: 8] = shifted[8*l +: 8];
                end
            end
        end
    endtask

    task automatic nextCycle();
        @(negedge Clock);
        inFabricValid = 1'b0;
        dmemWrEn      = 1'b0;
        dmemRdEn      = 1'b0;
    endtask

    task automatic waitReady();
        while (!ready) begin
            @(negedge Clock);
        end
    endtask

    task automatic drainQueues();
        while (rspQ.size() != 0 || reqQ.size() != 0) begin
            @(negedge Clock);
        end
        repeat (4) @(negedge Clock);   // Catch stray extras
    endtask

    // ==============================
    // Outgoing port monitor
    // ==============================
    always @(posedge Clock) begin
        logic [73:0] exp;
        logic        found;
        if (!reset && outFabricValid) begin
            found = 1'b0;
            exp   = '0;
            outCount++;
            if (outFabricOp == tilePkg::opRdRsp && rspQ.size() > 0) begin
                exp   = rspQ.pop_front();
                found = 1'b1;
            end else if (outFabricOp != tilePkg::opRdRsp && reqQ.size() > 0) begin
                exp   = reqQ.pop_front();
                found = 1'b1;
            end
            if (found) begin
                checkValue("outFabricAddr", outFabricAddr, exp[73:42]);
                checkValue("outFabricData", outFabricData, exp[41:10]);
                checkValue("outFabricOp", 32'(outFabricOp), 32'(exp[9:8]));
                checkValue("outFabricRequestorId", 32'(outFabricRequestorId), 32'(exp[7:0]));
            end else begin
                errors++;
                $display("Outgoing transaction with opcode %0d arrived while none was expected",
                         outFabricOp);
            end
        end
    end

    stallHoldsOutput: assert property (@(posedge Clock) disable iff (reset)
        !fabReady |-> !outFabricValid)
        else begin
            errors++;
            $display("CHECK FAILED outFabricValid: got 0x1, expected 0x0 with fabReady low");
        end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        logic [9:0]  idx;
        logic [31:0] addr;
        logic [31:0] exp;
        logic        sawStall;
        lfsr                = 32'h1a6c;
        reset               = 1'b1;
        localTileId         = myTile;
        pc                  = '0;
        dmemAddress         = '0;
        dmemWrData          = '0;
        dmemByteEn          = '0;
        dmemWrEn            = 1'b0;
        dmemRdEn            = 1'b0;
        inFabricValid       = 1'b0;
        inFabricAddr        = '0;
        inFabricData        = '0;
        inFabricOp          = '0;
        inFabricRequestorId = '0;
        fabReady            = 1'b1;
        repeat (10) @(negedge Clock);
        reset = 1'b0;
        checkValue("ready", 32'(ready), 32'h1);
        checkValue("outFabricValid", 32'(outFabricValid), 32'h0);

        // Fabric fills both memories, then fetches from the instruction memory
        for (int i = 0; i < 2 * numWords; i++) begin
            waitReady();
            startFabric(tilePkg::opWr, 4'(i / numWords), 10'(i % numWords), takeBits(32));
            nextCycle();
        end
        for (int i = 0; i < numFetch; i++) begin
            idx = 10'(takeBits(4));
            pc  = {20'h0, idx, 2'b00};
            nextCycle();
            checkValue("instruction", instruction, imemShadow[idx]);
        end

        // Byte, half and word stores at every offset, each read back
        for (int size = 0; size < 3; size++) begin
            for (int off = 0; off < 4; off++) begin
                idx = 10'(takeBits(4));
                waitReady();
                startCore(1'b1, localAddr(idx, 2'(off)), takeBits(32), 4'((1 << (1 << size)) - 1));
                nextCycle();
                addr = localAddr(idx, 2'(takeBits(2)));
                exp  = loadValue(addr);
                startCore(1'b0, addr, takeBits(32), 4'hF);
                nextCycle();
                checkValue("dmemRdRsp", dmemRdRsp, exp);
            end
        end

        // WhoAmI
        waitReady();
        startCore(1'b0, 32'h00FF_FFFF, 32'h0, 4'hF);
        nextCycle();
        checkValue("dmemRdRsp", dmemRdRsp, loadValue(32'h00FF_FFFF));

        // Fabric reads, regions 2 and 3 unmapped
        for (int i = 0; i < numFabReads; i++) begin
            waitReady();
            startFabric(tilePkg::opRd, 4'(takeBits(2)), 10'(takeBits(4)), takeBits(32));
            nextCycle();
        end
        drainQueues();

        // Foreign tile accesses leave as requests
        for (int i = 0; i < numForward; i++) begin
            waitReady();
            startCore(1'(takeBits(1)), foreignAddr(), takeBits(32), 4'hF);
            nextCycle();
        end
        drainQueues();
        for (int i = 0; i < numWords; i++) begin
            idx  = 10'(i);
            pc   = {20'h0, idx, 2'b00};
            addr = localAddr(idx, 2'b00);
            exp  = loadValue(addr);
            startCore(1'b0, addr, 32'h0, 4'hF);
            nextCycle();
            checkValue("instruction", instruction, imemShadow[idx]);
            checkValue("dmemRdRsp", dmemRdRsp, exp);
        end

        // Back-pressure, mixed traffic until ready drops
        fabReady = 1'b0;
        sawStall = 1'b0;
        for (int i = 0; i < stallCycles; i++) begin
            if (!ready) begin
                sawStall = 1'b1;
            end else if (i % 2 == 0) begin
                startFabric(tilePkg::opRd, 4'(takeBits(2)), 10'(takeBits(4)), 32'h0);
            end else begin
                startCore(1'(takeBits(1)), foreignAddr(), takeBits(32), 4'hF);
            end
            nextCycle();
        end
        checks++;
        assert (sawStall) else begin
            errors++;
            $display("ready never fell while fabReady was held low");
        end
        fabReady = 1'b1;
        drainQueues();

        $display("Checks: %0d, errors: %0d, outgoing transactions: %0d", checks, errors, outCount);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired after %0d cycles, %0d responses and %0d requests pending",
                 watchdogCycles, rspQ.size(), reqQ.size());
        $display("Test failures found");
        $finish;
    end

endmodule
